// ==== tb/fifo_stim.txt ====
// columns: push pop data, one line per clock cycle, all fields in hex
// push and pop are 0 or 1, data is the word offered with the push
0 0 0000
1 0 a001
0 0 0000
0 0 0000
0 1 0000
0 1 0000
1 0 b001
1 0 b002
1 0 b003
1 0 b004
1 0 b005
1 0 b006
1 0 b007
1 0 b008
1 0 b009
1 0 b00a
1 0 b00b
0 0 0000
1 1 c001
1 1 c002
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
1 1 d001
1 1 d002
1 1 d003
1 1 d004
1 1 d005
1 1 d006
0 1 0000
0 1 0000
0 1 0000
0 1 0000
1 0 e001
1 0 e002
1 0 e003
1 0 e004
1 0 e005
1 1 e006
1 1 e007
1 1 e008
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 1 0000
0 0 0000

// ==== flist.f ====
+incdir+design
design/fifo_pkg.sv
design/mem_1r1w_sync.sv
design/fifo_ptr_counter.sv
design/fifo_fwft_ctrl.sv
design/fifo_fwft_top.sv
tb/tb_clk_gen.sv
tb/fifo_assert.sv
tb/fifo_tb.sv

// ==== Makefile ====
TOP := fifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb/fifo_tb.sv ====
// FWFT FIFO testbench
`include "fifo_macros.svh"

module fifo_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RAND_CYCLES = 200;

   logic             clk_lo;
   logic             reset_i;
   logic             push_i;
   fifo_pkg::data_t  push_data_i;
   logic             pop_i;
   logic             full_o;
   logic             valid_o;
   fifo_pkg::data_t  pop_data_o;

   // stimulus from the file with one entry per cycle
   logic             stim_push [$];
   logic             stim_pop [$];
   fifo_pkg::data_t  stim_data [$];
   int               stim_lines = 0;
   logic             stim_loaded = 1'b0;

   // reference model holding every accepted item in push order with the head first
   fifo_pkg::data_t  model_q [$];
   logic             model_valid;

   int               checks = 0;
   int               value_errors = 0;
   int               other_errors = 0;
   int               pops_done = 0;
   logic             full_seen = 1'b0;

   tb_clk_gen clk_gen
   (
      .clk_lo (clk_lo)
   );

   fifo_fwft_top DUT
   (
      .clk_lo      (clk_lo),
      .reset_i     (reset_i),
      .push_i      (push_i),
      .push_data_i (push_data_i),
      .full_o      (full_o),
      .pop_i       (pop_i),
      .valid_o     (valid_o),
      .pop_data_o  (pop_data_o)
   );

   task automatic load_stim();
      int    fd;
      int    n;
      int    p;
      int    q;
      int    d;
      string line;
      fd = $fopen("tb/fifo_stim.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file tb/fifo_stim.txt");
         other_errors++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines do not give three fields
            n = $sscanf(line, "%h %h %h", p, q, d);
            if (n == 3)
            begin
               stim_push.push_back(p != 0);
               stim_pop.push_back(q != 0);
               stim_data.push_back(fifo_pkg::data_t'(d));
            end
         end
         $fclose(fd);
         stim_lines = stim_push.size();
      end
      stim_loaded = 1'b1;
   endtask

   // compare DUT outputs with the model between clock edges
   task automatic check_outputs();
      int   ram_items;
      logic exp_full;
      ram_items = model_q.size() - (model_valid ? 1 : 0);
      exp_full = (ram_items == `FIFO_DEPTH);
      checks++;
      assert (valid_o === model_valid)
      else
      begin
         $display("** Error at %0d ns: valid_o is %b, expected %b",
                  $time, valid_o, model_valid);
         value_errors++;
      end
      assert (full_o === exp_full)
      else
      begin
         $display("** Error at %0d ns: full_o is %b, expected %b", $time, full_o, exp_full);
         value_errors++;
      end
      if (model_valid && valid_o)
      begin
         assert (pop_data_o === model_q[0])
         else
         begin
            $display("** Error at %0d ns: pop_data_o is %h, expected head %h",
                     $time, pop_data_o, model_q[0]);
            value_errors++;
         end
      end
   endtask

   // apply one cycle of inputs to the model as the DUT sees them at the next edge
   task automatic update_model(input logic push, input logic pop, input fifo_pkg::data_t data);
      int   ram_items;
      logic rd;
      logic popped;
      ram_items = model_q.size() - (model_valid ? 1 : 0);
      popped = pop && model_valid;
      // next item moves to the output when the RAM has one and the output is free or freed
      rd = (ram_items > 0) && (!model_valid || pop);
      if (ram_items == `FIFO_DEPTH)
      begin
         full_seen = 1'b1;
      end
      if (popped)
      begin
         void'(model_q.pop_front());
         pops_done++;
      end
      // pushes while full are lost
      if (push && (ram_items < `FIFO_DEPTH))
      begin
         model_q.push_back(data);
      end
      if (rd)
      begin
         model_valid = 1'b1;
      end
      else if (popped)
      begin
         model_valid = 1'b0;
      end
   endtask

   task automatic run_cycle(input logic push, input logic pop, input fifo_pkg::data_t data);
      @(posedge clk_lo);
      push_i      <= push;
      pop_i       <= pop;
      push_data_i <= data;
      // outputs are settled half a period after the edge
      @(negedge clk_lo);
      check_outputs();
      update_model(push, pop, data);
   endtask

   initial
   begin
      int   push_pct;
      int   pop_pct;
      logic rnd_push;
      logic rnd_pop;
      void'($urandom(72));
      reset_i     <= 1'b1;
      push_i      <= 1'b0;
      pop_i       <= 1'b0;
      push_data_i <= '0;
      model_valid = 1'b0;
      load_stim();
      repeat (2) @(posedge clk_lo);
      reset_i <= 1'b0;

      // directed part from the file
      for (int i = 0; i < stim_lines; i++)
      begin
         run_cycle(stim_push[i], stim_pop[i], stim_data[i]);
      end

      // random traffic that fills first, drains next and ends balanced
      for (int i = 0; i < RAND_CYCLES; i++)
      begin
         if (i < 60)
         begin
            push_pct = 80;
            pop_pct  = 25;
         end
         else if (i < 120)
         begin
            push_pct = 25;
            pop_pct  = 80;
         end
         else
         begin
            push_pct = 50;
            pop_pct  = 50;
         end
         rnd_push = (($urandom % 100) < push_pct);
         rnd_pop  = (($urandom % 100) < pop_pct);
         run_cycle(rnd_push, rnd_pop, fifo_pkg::data_t'($urandom));
      end
      run_cycle(1'b0, 1'b0, '0);
      run_cycle(1'b0, 1'b0, '0);

      if (!full_seen || pops_done == 0)
      begin
         $display("stimulus never filled the FIFO or never popped an item");
         other_errors++;
      end
      if (DUT.checks.fails != 0)
      begin
         $display("bound assertions failed %0d times", DUT.checks.fails);
         other_errors++;
      end
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // watchdog at ten times the expected run length
   initial
   begin
      wait (stim_loaded);
      repeat (10 * (stim_lines + RAND_CYCLES + 20)) @(posedge clk_lo);
      $display("watchdog timeout, the run did not finish in time");
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// ==== tb/fifo_assert.sv ====
// FIFO bound assertions
module fifo_assert
(
   input logic             clk_lo,
   input logic             reset_i,
   input logic             wr_v_i,
   input logic             rd_v_i,
   input fifo_pkg::addr_t  wr_addr_i,
   input fifo_pkg::addr_t  rd_addr_i,
   input logic             full_i,
   input logic             valid_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // number of failed assertions, read by the testbench top
   int fails = 0;

   // the read ahead never targets the entry being written
   no_same_addr: assert property (@(posedge clk_lo) disable iff (reset_i)
      !(wr_v_i && rd_v_i && (wr_addr_i == rd_addr_i)))
   else
   begin
      $error("RAM read and write hit the same address in one cycle");
      fails++;
   end

   // a push while full must be dropped before it reaches the RAM
   no_write_when_full: assert property (@(posedge clk_lo) disable iff (reset_i)
      !(full_i && wr_v_i))
   else
   begin
      $error("RAM write strobe while the FIFO is full");
      fails++;
   end

   // output starts empty once reset is released
   empty_after_reset: assert property (@(posedge clk_lo) reset_i |=> !valid_i)
   else
   begin
      $error("valid_o high in the cycle after reset");
      fails++;
   end

endmodule

bind fifo_fwft_top fifo_assert checks
(
   .clk_lo    (clk_lo),
   .reset_i   (reset_i),
   .wr_v_i    (wr_v),
   .rd_v_i    (rd_v),
   .wr_addr_i (wr_addr),
   .rd_addr_i (rd_addr),
   .full_i    (full_o),
   .valid_i   (valid_o)
);

// ==== tb/tb_clk_gen.sv ====
// testbench clock source
module tb_clk_gen
(
   output logic clk_lo
);
   timeunit 1ns;
   timeprecision 1ps;

   // 10 ns period, first rising edge at 5 ns
   initial
   begin
      clk_lo = 1'b0;
      forever
      begin
         #5 clk_lo = ~clk_lo;
      end
   end

endmodule

// ==== design/fifo_fwft_top.sv ====
// FWFT FIFO top level
module fifo_fwft_top
(
   input  logic             clk_lo,
   input  logic             reset_i,

   // producer side
   input  logic             push_i,
   input  fifo_pkg::data_t  push_data_i,
   output logic             full_o,

   // consumer side
   input  logic             pop_i,
   output logic             valid_o,
   output fifo_pkg::data_t  pop_data_o
);

   logic             wr_v;
   logic             rd_v;
   logic             ram_empty;
   fifo_pkg::addr_t  wr_addr;
   fifo_pkg::addr_t  rd_addr;

   // output side FSM, also gates pushes against full
   fifo_fwft_ctrl ctrl
   (
      .clk_lo      (clk_lo),
      .reset_i     (reset_i),
      .ram_empty_i (ram_empty),
      .full_i      (full_o),
      .push_i      (push_i),
      .pop_i       (pop_i),
      .wr_v_o      (wr_v),
      .rd_v_o      (rd_v),
      .valid_o     (valid_o)
   );

   fifo_ptr_counter ptrs
   (
      .clk_lo      (clk_lo),
      .reset_i     (reset_i),
      .wr_v_i      (wr_v),
      .rd_v_i      (rd_v),
      .wr_addr_o   (wr_addr),
      .rd_addr_o   (rd_addr),
      .ram_empty_o (ram_empty),
      .full_o      (full_o)
   );

   // RAM output register doubles as the FIFO output stage
   mem_1r1w_sync ram
   (
      .clk_lo      (clk_lo),
      .w_v_i       (wr_v),
      .w_addr_i    (wr_addr),
      .w_data_i    (push_data_i),
      .r_v_i       (rd_v),
      .r_addr_i    (rd_addr),
      .r_data_o    (pop_data_o)
   );

endmodule

// ==== design/fifo_fwft_ctrl.sv ====
// FWFT read ahead control
module fifo_fwft_ctrl
(
   input  logic  clk_lo,
   input  logic  reset_i,

   // status from the pointer block
   input  logic  ram_empty_i,
   input  logic  full_i,

   // producer and consumer strobes
   input  logic  push_i,
   input  logic  pop_i,

   // accepted write, read ahead, and head item present
   output logic  wr_v_o,
   output logic  rd_v_o,
   output logic  valid_o
);

   fifo_pkg::ctrl_state_t state_r;
   fifo_pkg::ctrl_state_t state_n;

   // a push while full is dropped here
   assign wr_v_o = push_i & ~full_i;

   // head item is visible whenever the RAM output register holds one
   assign valid_o = (state_r == fifo_pkg::S_VALID);

   // read ahead when the RAM has data and the output slot is free
   // or is being freed by a pop in this cycle
   // uses the registered count, so a write in the same cycle is never read
   assign rd_v_o = ~ram_empty_i & (~valid_o | pop_i);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         fifo_pkg::S_EMPTY:
         begin
            // the read lands at this edge, head is valid after it
            if (rd_v_o)
            begin
               state_n = fifo_pkg::S_VALID;
            end
         end
         fifo_pkg::S_VALID:
         begin
            // pop with nothing left behind it empties the output
            if (pop_i && !rd_v_o)
            begin
               state_n = fifo_pkg::S_EMPTY;
            end
         end
         default:
         begin
            state_n = fifo_pkg::S_EMPTY;
         end
      endcase
   end

   always_ff @(posedge clk_lo)
   begin
      if (reset_i)
      begin
         state_r <= fifo_pkg::S_EMPTY;
      end
      else
      begin
         state_r <= state_n;
      end
   end

endmodule

// ==== design/fifo_ptr_counter.sv ====
// FIFO pointers and occupancy
`include "fifo_macros.svh"

module fifo_ptr_counter
(
   input  logic             clk_lo,
   input  logic             reset_i,

   // accepted write and read ahead strobes
   input  logic             wr_v_i,
   input  logic             rd_v_i,

   // RAM addresses for the next write and the next read
   output fifo_pkg::addr_t  wr_addr_o,
   output fifo_pkg::addr_t  rd_addr_o,

   // occupancy flags from the registered count
   output logic             ram_empty_o,
   output logic             full_o
);

   fifo_pkg::addr_t  wr_ptr_r;
   fifo_pkg::addr_t  rd_ptr_r;
   fifo_pkg::count_t count_r;

   // advance a pointer by one entry and wrap at the RAM depth
   // depth need not be a power of two
   function automatic fifo_pkg::addr_t ptr_next(input fifo_pkg::addr_t ptr);
      fifo_pkg::addr_t nxt;
      if (ptr == fifo_pkg::addr_t'(`FIFO_DEPTH - 1))
      begin
         nxt = '0;
      end
      else
      begin
         nxt = ptr + fifo_pkg::addr_t'(1);
      end
      return nxt;
   endfunction

   // write pointer moves on every accepted push
   always_ff @(posedge clk_lo)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
      end
      else if (wr_v_i)
      begin
         wr_ptr_r <= ptr_next(wr_ptr_r);
      end
   end

   // read pointer moves on every read ahead
   always_ff @(posedge clk_lo)
   begin
      if (reset_i)
      begin
         rd_ptr_r <= '0;
      end
      else if (rd_v_i)
      begin
         rd_ptr_r <= ptr_next(rd_ptr_r);
      end
   end

   // occupancy of the RAM itself
   // the item in the RAM output register is no longer counted
   always_ff @(posedge clk_lo)
   begin
      if (reset_i)
      begin
         count_r <= '0;
      end
      else
      begin
         case ({wr_v_i, rd_v_i})
            2'b10:   count_r <= count_r + fifo_pkg::count_t'(1);
            2'b01:   count_r <= count_r - fifo_pkg::count_t'(1);
            // both or neither leave the count alone
            default: count_r <= count_r;
         endcase
      end
   end

   assign wr_addr_o   = wr_ptr_r;
   assign rd_addr_o   = rd_ptr_r;
   assign ram_empty_o = (count_r == '0);
   assign full_o      = (count_r == fifo_pkg::count_t'(`FIFO_DEPTH));

endmodule

// ==== design/mem_1r1w_sync.sv ====
// one read one write synchronous RAM
`include "fifo_macros.svh"

module mem_1r1w_sync
(
   input  logic             clk_lo,

   // write port
   input  logic             w_v_i,
   input  fifo_pkg::addr_t  w_addr_i,
   input  fifo_pkg::data_t  w_data_i,

   // read port
   input  logic             r_v_i,
   input  fifo_pkg::addr_t  r_addr_i,
   output fifo_pkg::data_t  r_data_o
);

   // storage array, contents are undefined until written
   fifo_pkg::data_t mem_r [`FIFO_DEPTH];

   // output register, keeps the word of the last read
   fifo_pkg::data_t r_data_r;

   // write port
   // a write lands in the array at the end of the cycle
   always_ff @(posedge clk_lo)
   begin
      if (w_v_i)
      begin
         mem_r[w_addr_i] <= w_data_i;
      end
   end

   // read port
   // the addressed word is registered on a read strobe
   // with no strobe the register simply holds its value,
   // which is what lets the FIFO present its head item
   // for as many cycles as the consumer needs
   always_ff @(posedge clk_lo)
   begin
      if (r_v_i)
      begin
         r_data_r <= mem_r[r_addr_i];
      end
   end

   // no bypass path from the write port
   // the control never reads an entry that is written in the same cycle
   assign r_data_o = r_data_r;

endmodule

// ==== design/fifo_pkg.sv ====
// FIFO shared types
`include "fifo_macros.svh"

package fifo_pkg;

   // one data word as pushed by the producer and seen by the consumer
   typedef logic [`FIFO_WIDTH-1:0] data_t;

   // RAM address, used by both write and read pointers
   typedef logic [`FIFO_ADDR_W-1:0] addr_t;

   // RAM occupancy from 0 up to FIFO_DEPTH inclusive
   // needs one bit more than the address to hold the full value
   typedef logic [`FIFO_ADDR_W:0] count_t;

   // output side control FSM
   // S_EMPTY  nothing presented at the output
   // S_VALID  the RAM output register holds the head item
   typedef enum logic [0:0]
   {
      S_EMPTY = 1'b0,
      S_VALID = 1'b1
   } ctrl_state_t;

endpackage

// ==== design/fifo_macros.svh ====
// FIFO configuration macros
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// width of one stored data word in bits
`define FIFO_WIDTH 16

// number of entries in the backing RAM
// total FIFO capacity is one more, the extra item sits in the RAM output register
`define FIFO_DEPTH 8

// address width of the RAM, follows from the depth
`define FIFO_ADDR_W $clog2(`FIFO_DEPTH)

`endif
